// ==== vote_top.f ====
+incdir+.
vote_pkg.sv
vote_selector.sv
vote_counter.sv
vote_ctrl.sv
vote_top.sv
vote_top_checker.sv
vote_top_tb.sv

// ==== Makefile ====
SIM      = verilator
TOP      = vote_top_tb
FILELIST = vote_top.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
FAIL_MSG = Simulation failed

SOURCES  = $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  = $(wildcard *.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== vote_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vote_defines.svh"

module vote_top_tb;

    import vote_pkg::*;

    typedef vote_in_t beat_q_t[$];

    localparam int clk_period   = 4;
    localparam int seed         = 96;
    localparam int n_random     = 60;
    // upper bound on batches over the whole run
    localparam int batch_count  = 120;
    // longest random batch plus drain, report and idle slack
    localparam int max_batch    = 40 + `VOTE_DRAIN + 4;
    localparam int margin_ns    = 2000;
    localparam int watchdog_ns  = batch_count * max_batch * clk_period + margin_ns;

    logic      clk;
    logic      rst;
    vote_in_t  vote_in;
    logic      finish;
    logic      ready;
    logic      result_valid;
    logic      result_sign;
    beat_cnt_t result_beats;

    // beats accepted in the open batch
    beat_q_t   batch_beats;
    // expected results, one entry per finished batch
    logic      exp_sign_q[$];
    int        exp_beats_q[$];
    int        errors;
    int        checks;

    vote_top dut (
        .clk          (clk),
        .rst          (rst),
        .vote_in      (vote_in),
        .finish       (finish),
        .ready        (ready),
        .result_valid (result_valid),
        .result_sign  (result_sign),
        .result_beats (result_beats)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // 1 when the batch sum is negative
    // storing core adds +1 for result 1 and -1 for result 0
    function automatic logic expected_sign(input beat_q_t beats_in);
        int sum;
        sum = 0;
        foreach (beats_in[b]) begin
            for (int c = 0; c < `VOTE_CORES; c++) begin
                if (beats_in[b].store[c]) begin
                    sum = sum + (beats_in[b].core_result[c] ? 1 : -1);
                end
            end
        end
        return (sum < 0);
    endfunction

    // beats with at least one store
    function automatic int count_beats(input beat_q_t beats_in);
        int n;
        n = 0;
        foreach (beats_in[b]) begin
            if (beats_in[b].store != '0) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic vote_in_t make_beat(input core_vec_t s, input core_vec_t r);
        vote_in_t v;
        v.store       = s;
        v.core_result = r;
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // queue the expected values of the open batch for the compare process
    task automatic close_batch();
        exp_sign_q.push_back(expected_sign(batch_beats));
        exp_beats_q.push_back(count_beats(batch_beats));
        batch_beats.delete();
    endtask

    // drive one beat once ready is high
    task automatic send_beat(input vote_in_t v, input logic fin);
        @(negedge clk);
        while (!ready) begin
            vote_in = '0;
            finish  = 1'b0;
            @(negedge clk);
        end
        vote_in = v;
        finish  = fin;
        batch_beats.push_back(v);
        if (fin) begin
            close_batch();
        end
    endtask

    // stores during drain and report are not recorded
    task automatic drive_while_busy(input vote_in_t pattern, input logic use_random);
        @(negedge clk);
        while (!ready) begin
            if (use_random) begin
                vote_in = make_beat(core_vec_t'($urandom), core_vec_t'($urandom));
            end else begin
                vote_in = pattern;
            end
            finish = 1'b0;
            @(negedge clk);
        end
        vote_in = '0;
        finish  = 1'b0;
    endtask

    task automatic random_batch(input int len);
        vote_in_t v;
        for (int b = 0; b < len; b++) begin
            // some beats carry no store at all
            v.store       = ($urandom % 8 == 0) ? '0 : core_vec_t'($urandom);
            v.core_result = core_vec_t'($urandom);
            send_beat(v, (b == len - 1));
        end
    endtask

    // compare each report against the oldest pending batch
    initial begin : compare_results
        forever begin
            @(negedge clk);
            if (result_valid) begin
                if (exp_sign_q.size() == 0) begin
                    errors++;
                    $display("result pulse at %0t with no finished batch pending", $time);
                end else begin
                    check("result_sign", 32'(result_sign), 32'(exp_sign_q.pop_front()));
                    check("result_beats", 32'(result_beats), 32'(exp_beats_q.pop_front()));
                end
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("timeout: run did not finish within %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        int unsigned seed_ret;
        int          len;
        rst     = 1'b1;
        vote_in = '0;
        finish  = 1'b0;
        errors  = 0;
        checks  = 0;
        seed_ret = $urandom(seed);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle levels and an empty batch
        @(negedge clk);
        check("ready", 32'(ready), 32'd1);
        check("result_valid", 32'(result_valid), 32'd0);
        send_beat('0, 1'b1);

        // one core per batch with an up vote and then a down vote
        for (int k = 0; k < `VOTE_CORES; k++) begin
            send_beat(make_beat(core_vec_t'(1) << k, core_vec_t'(1) << k), 1'b1);
            send_beat(make_beat(core_vec_t'(1) << k, '0), 1'b1);
        end

        // sums of exactly 0, +1 and -1
        send_beat(make_beat(16'hffff, 16'hffff), 1'b0);
        send_beat(make_beat(16'hffff, 16'h0000), 1'b0);
        send_beat(make_beat(16'hffff, 16'h00ff), 1'b1);
        send_beat(make_beat(16'hffff, 16'h00ff), 1'b0);
        send_beat(make_beat(16'h0001, 16'h0001), 1'b1);
        send_beat(make_beat(16'hffff, 16'hffff), 1'b0);
        send_beat(make_beat(16'hffff, 16'h0000), 1'b0);
        send_beat(make_beat(16'h0003, 16'h0002), 1'b0);
        send_beat(make_beat(16'h0001, 16'h0000), 1'b1);

        // strongly negative stores while busy must not leak into a +1 batch
        send_beat(make_beat(16'hffff, 16'h0000), 1'b1);
        drive_while_busy(make_beat(16'hffff, 16'h0000), 1'b0);
        send_beat(make_beat(16'h0001, 16'h0001), 1'b1);

        // random batches on consecutive cycles with busy stores after some
        for (int i = 0; i < n_random; i++) begin
            len = 1 + int'($urandom % 40);
            random_batch(len);
            if (i % 4 == 0) begin
                drive_while_busy('0, 1'b1);
            end
        end

        // back to back batches with finish on the first ready cycle
        for (int i = 0; i < 8; i++) begin
            send_beat(make_beat(core_vec_t'($urandom), core_vec_t'($urandom)), 1'b1);
        end
        random_batch(2);
        send_beat(make_beat(16'h8000, 16'h0000), 1'b1);

        @(negedge clk);
        vote_in = '0;
        finish  = 1'b0;
        // let the last reports come back
        while (exp_sign_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vote_top_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module vote_top_checker (
    input logic clk,
    input logic rst,
    input logic ready,
    input logic result_valid,
    input logic clear
);

    // report is a single cycle pulse, never held
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (rst)
        result_valid |=> !result_valid
    ) else $error("result_valid stayed high for more than one cycle");

    // no new votes accepted while reporting
    a_ready_low: assert property (
        @(posedge clk) disable iff (rst)
        result_valid |-> !ready
    ) else $error("ready high while result_valid is high");

    // tally clear only on the report cycle
    a_clear_with_valid: assert property (
        @(posedge clk) disable iff (rst)
        clear |-> result_valid
    ) else $error("clear raised outside the report cycle");

    // controller comes out of reset idle
    a_reset_idle: assert property (
        @(posedge clk)
        rst |=> !result_valid
    ) else $error("result_valid high right after reset");

endmodule

bind vote_ctrl vote_top_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .ready        (ready),
    .result_valid (result_valid),
    .clear        (clear)
);

`default_nettype wire

// ==== vote_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vote_top (
    input  logic                clk,
    input  logic                rst,
    input  vote_pkg::vote_in_t  vote_in,
    input  logic                finish,
    output logic                ready,
    output logic                result_valid,
    output logic                result_sign,
    output vote_pkg::beat_cnt_t result_beats
);

    import vote_pkg::*;

    // votes after the controller has dropped out-of-batch stores
    vote_in_t gated_in;
    // end of batch clear, tally back to zero
    logic     clear;
    // current sign of the running tally
    logic     sign_bit;

    // batch controller
    vote_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .vote_in      (vote_in),
        .finish       (finish),
        .sign_bit     (sign_bit),
        .gated_in     (gated_in),
        .clear        (clear),
        .ready        (ready),
        .result_valid (result_valid),
        .result_sign  (result_sign),
        .result_beats (result_beats)
    );

    // three stage vote pipeline
    vote_counter u_counter (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .vote_in  (gated_in),
        .sign_bit (sign_bit)
    );

endmodule

`default_nettype wire

// ==== vote_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vote_defines.svh"

module vote_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  vote_pkg::vote_in_t  vote_in,
    input  logic                finish,
    input  logic                sign_bit,
    output vote_pkg::vote_in_t  gated_in,
    output logic                clear,
    output logic                ready,
    output logic                result_valid,
    output logic                result_sign,
    output vote_pkg::beat_cnt_t result_beats
);

    import vote_pkg::*;

    // drain counter holds VOTE_DRAIN-1 down to 0
    localparam int drain_w = $clog2(`VOTE_DRAIN + 1);

    ctrl_state_t        state;
    logic [drain_w-1:0] drain_cnt;
    beat_cnt_t          beat_cnt;
    logic               beat_accept;

    // stores only reach the counter while accumulating
    // anything sent during drain or report is dropped here
    always_comb begin
        gated_in = vote_in;
        if (state != ACCUM) begin
            gated_in.store = '0;
        end
    end

    // a beat counts when at least one core stores
    assign beat_accept = |gated_in.store;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ACCUM;
            drain_cnt <= '0;
            beat_cnt  <= '0;
        end else begin
            case (state)
                ACCUM: begin
                    // finish beat may carry stores of its own
                    if (beat_accept) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (finish) begin
                        state     <= DRAIN;
                        drain_cnt <= drain_w'(`VOTE_DRAIN - 1);
                    end
                end
                DRAIN: begin
                    // wait until the last beat has reached the tally
                    if (drain_cnt == '0) begin
                        state <= REPORT;
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                REPORT: begin
                    // one cycle only, then back for the next batch
                    state    <= ACCUM;
                    beat_cnt <= '0;
                end
                default: begin
                    state <= ACCUM;
                end
            endcase
        end
    end

    // handshake levels decoded from state
    assign ready        = (state == ACCUM);
    assign result_valid = (state == REPORT);
    // tally clears on the edge that leaves report
    assign clear        = (state == REPORT);

    // sign is settled by the time report is reached
    assign result_sign  = sign_bit;
    assign result_beats = beat_cnt;

endmodule

`default_nettype wire

// ==== vote_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vote_defines.svh"

module vote_counter (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  vote_pkg::vote_in_t vote_in,
    output logic               sign_bit
);

    import vote_pkg::*;

    // number of group adders
    localparam int groups = `VOTE_CORES / `VOTE_GROUP;

    // any core storing this beat
    logic store_any;
    // store strobe delayed to line up with votes, then with group sums
    logic store_n;
    logic store_nn;

    // per core votes, stage one
    vote_t votes [`VOTE_CORES];
    // group sums, stage two
    group_sum_t group_sum [groups];
    // running total, stage three
    tally_t tally;
    tally_t tally_next;

    assign store_any = |vote_in.store;

    // one selector per core
    for (genvar k = 0; k < `VOTE_CORES; k++) begin : g_sel
        vote_selector u_sel (
            .clk             (clk),
            .rst             (rst),
            .store_bit       (vote_in.store[k]),
            .core_result_bit (vote_in.core_result[k]),
            .vote            (votes[k])
        );
    end

    // two stage strobe delay
    // separate strobes per stage so stores can come every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            store_n  <= 1'b0;
            store_nn <= 1'b0;
        end else begin
            store_n  <= store_any;
            store_nn <= store_n;
        end
    end

    // four group adders, each over four neighbouring cores
    for (genvar g = 0; g < groups; g++) begin : g_grp
        group_sum_t group_next;

        always_comb begin
            group_next = '0;
            for (int i = 0; i < `VOTE_GROUP; i++) begin
                // sign extend each 2 bit vote before adding
                group_next = group_next + group_sum_t'(votes[g * `VOTE_GROUP + i]);
            end
        end

        always_ff @(posedge clk) begin
            if (rst || clear) begin
                group_sum[g] <= '0;
            end else if (store_n) begin
                group_sum[g] <= group_next;
            end
        end
    end

    // add all group sums onto the total
    always_comb begin
        tally_next = tally;
        for (int g = 0; g < groups; g++) begin
            tally_next = tally_next + group_sum[g];
        end
    end

    // tally only moves on the second delayed strobe
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            tally <= '0;
        end else if (store_nn) begin
            tally <= tally_next;
        end
    end

    // negative total gives 1, zero counts as non-negative
    assign sign_bit = tally[`VOTE_TALLY_W-1];

endmodule

`default_nettype wire

// ==== vote_selector.sv ====
`timescale 1ns/1ps
`default_nettype none

module vote_selector (
    input  logic            clk,
    input  logic            rst,
    input  logic            store_bit,
    input  logic            core_result_bit,
    output vote_pkg::vote_t vote
);

    import vote_pkg::*;

    // vote encodings
    localparam vote_t vote_pos  = 2'sd1;
    localparam vote_t vote_neg  = -2'sd1;
    localparam vote_t vote_none = 2'sd0;

    // first pipeline stage
    // result 1 votes up, result 0 votes down, no store abstains
    always_ff @(posedge clk) begin
        if (rst) begin
            vote <= vote_none;
        end else if (store_bit) begin
            vote <= core_result_bit ? vote_pos : vote_neg;
        end else begin
            // idle core must not keep its old vote
            vote <= vote_none;
        end
    end

endmodule

`default_nettype wire

// ==== vote_pkg.sv ====
`default_nettype none

`include "vote_defines.svh"

package vote_pkg;

    // one bit per core
    typedef logic [`VOTE_CORES-1:0] core_vec_t;

    // single core vote, holds -1, 0 or +1
    typedef logic signed [1:0] vote_t;

    // group sum feeds the tally directly, so same width
    typedef logic signed [`VOTE_TALLY_W-1:0] group_sum_t;

    // running signed total
    typedef logic signed [`VOTE_TALLY_W-1:0] tally_t;

    // accepted beats in one batch
    typedef logic [`VOTE_BEAT_W-1:0] beat_cnt_t;

    // one cycle worth of votes from all cores
    typedef struct packed {
        core_vec_t store;
        core_vec_t core_result;
    } vote_in_t;

    // batch controller states
    typedef enum logic [1:0] {
        ACCUM,
        DRAIN,
        REPORT
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== vote_defines.svh ====
`ifndef VOTE_DEFINES_SVH
`define VOTE_DEFINES_SVH

// number of cores casting votes, fixed by the group adder tree
`define VOTE_CORES 16
// cores summed by one group adder
`define VOTE_GROUP 4
// signed tally width, enough for a count of 2^29
`define VOTE_TALLY_W 30
// accepted beat counter width
`define VOTE_BEAT_W 16
// cycles to wait after finish, same as pipeline depth
`define VOTE_DRAIN 3

`endif
